// File: sim.f
+incdir+include
hdl/pllg_types_pkg.sv
hdl/pllg_state_pkg.sv
hdl/amplitude_good.sv
hdl/phase_window_lock.sv
hdl/hold_controller.sv
hdl/pllg_top.sv
tb/tb_pllg_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PLL guard testbench with Verilator.
# Exits non-zero when the build, the run or the testbench fails.

cd "$(dirname "$0")" || exit 1

TOP=tb_pllg_top
BUILD_DIR=obj_dir
LOG=sim.log

echo "Building $TOP"
verilator --binary --timing --assert \
    -f sim.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR"
status=$?
if [ "$status" -ne 0 ]; then
    echo "ERROR: Verilator build failed with status $status"
    exit 1
fi

if [ ! -x "$BUILD_DIR/V$TOP" ]; then
    echo "ERROR: simulation executable not found"
    exit 1
fi

echo "Running $TOP"
"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "ERROR: simulation exited with status $status"
    exit 1
fi

# Verdict comes from the testbench log
if grep -q "tests failed" "$LOG"; then
    echo "RESULT: FAIL"
    exit 1
fi

echo "RESULT: PASS"
exit 0

// File: tb/tb_pllg_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pllg_top;

    localparam int ROW_CYCLES   = 64;
    localparam int RST_CYCLES   = 5;
    localparam int NUM_DIRECTED = 10;
    localparam int NUM_RANDOM   = 8;
    localparam int NUM_ROWS     = NUM_DIRECTED + NUM_RANDOM;
    // Release takes at least 17 cycles, so hold is still up here
    localparam int EARLY_CYCLE  = 8;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * ROW_CYCLES + RST_CYCLES + 100;

    logic                         aclk;
    logic                         rst_n;
    pllg_types_pkg::amp_t         amp_data;
    logic                         amp_valid;
    pllg_types_pkg::amp_t         amp_thr;
    pllg_types_pkg::phase_t       phase_data;
    logic                         phase_valid;
    pllg_types_pkg::phase_lim_t   phase_limit;
    logic                         hold;
    pllg_state_pkg::hold_reason_t hold_reason;

    // Stimulus table with one entry per row
    pllg_types_pkg::amp_t         row_amp[$];
    pllg_types_pkg::amp_t         row_thr[$];
    pllg_types_pkg::phase_t       row_phase[$];
    pllg_types_pkg::phase_lim_t   row_limit[$];
    logic                         row_alt[$];
    logic                         row_hold[$];
    pllg_state_pkg::hold_reason_t row_reason[$];

    logic [31:0] lcg_state = 32'd34229;
    int          cycle_cnt = 0;
    int          hold_errs = 0;
    int          reason_errs = 0;
    int          cur_row;
    int          cur_cyc;
    logic        prev_bad;

    pllg_top i_dut
    (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .amp_data    (amp_data),
        .amp_valid   (amp_valid),
        .amp_thr     (amp_thr),
        .phase_data  (phase_data),
        .phase_valid (phase_valid),
        .phase_limit (phase_limit),
        .hold        (hold),
        .hold_reason (hold_reason)
    );

    initial
    begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // Run limit
    always @(posedge aclk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Hold reason expected for one row of inputs
    function automatic pllg_state_pkg::hold_reason_t expected_reason(
        input pllg_types_pkg::amp_t       amp,
        input pllg_types_pkg::amp_t       thr,
        input pllg_types_pkg::phase_t     phase,
        input pllg_types_pkg::phase_lim_t limit
    );
        logic   amp_bad;
        logic   phase_bad;
        longint mag;
        // Good amplitude means strictly above threshold
        amp_bad = (amp <= thr);
        mag = longint'($signed(phase));
        if (mag < 0)
            mag = -mag;
        // Window edge is inside
        phase_bad = (mag > longint'({32'd0, limit}));
        if (amp_bad && phase_bad)
            return pllg_state_pkg::REASON_BOTH;
        else if (amp_bad)
            return pllg_state_pkg::REASON_AMP_LOW;
        else if (phase_bad)
            return pllg_state_pkg::REASON_PHASE_UNLOCK;
        else
            return pllg_state_pkg::REASON_NONE;
    endfunction

    task automatic add_row(
        input pllg_types_pkg::amp_t         amp,
        input pllg_types_pkg::amp_t         thr,
        input pllg_types_pkg::phase_t       phase,
        input pllg_types_pkg::phase_lim_t   limit,
        input logic                         alt,
        input logic                         exp_hold,
        input pllg_state_pkg::hold_reason_t exp_reason
    );
        row_amp.push_back(amp);
        row_thr.push_back(thr);
        row_phase.push_back(phase);
        row_limit.push_back(limit);
        row_alt.push_back(alt);
        row_hold.push_back(exp_hold);
        row_reason.push_back(exp_reason);
    endtask

    // Thresholds and limits land within 2 of the samples
    task automatic add_random_row();
        pllg_types_pkg::amp_t       amp;
        pllg_types_pkg::amp_t       thr;
        pllg_types_pkg::phase_t     phase;
        pllg_types_pkg::phase_lim_t limit;
        pllg_types_pkg::phase_lim_t mag;
        logic [31:0]                r_amp;
        logic [31:0]                r_thr;
        logic [31:0]                r_ph;
        logic [31:0]                r_lim;
        pllg_state_pkg::hold_reason_t reason;
        r_amp = lcg_rand();
        r_thr = lcg_rand();
        r_ph  = lcg_rand();
        r_lim = lcg_rand();
        amp   = r_amp;
        thr   = amp - 32'd2 + {29'd0, r_thr[18:16] % 3'd5};
        mag   = {12'd0, r_ph[27:8]} + 32'd2;
        phase = r_ph[31] ? (32'd0 - mag) : mag;
        limit = mag - 32'd2 + {29'd0, r_lim[18:16] % 3'd5};
        reason = expected_reason(amp, thr, phase, limit);
        add_row(amp, thr, phase, limit, r_lim[24], reason != pllg_state_pkg::REASON_NONE,
                reason);
    endtask

    task automatic check_hold(input logic exp_hold);
        if (hold !== exp_hold)
        begin
            $display("[FAIL] row %0d cycle %0d hold expected 0x%0h got 0x%0h",
                     cur_row, cur_cyc, exp_hold, hold);
            hold_errs++;
        end
    endtask

    task automatic check_reason(input pllg_state_pkg::hold_reason_t exp_reason);
        if (hold_reason !== exp_reason)
        begin
            $display("[FAIL] row %0d cycle %0d hold_reason expected 0x%0h got 0x%0h",
                     cur_row, cur_cyc, exp_reason, hold_reason);
            reason_errs++;
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        rst_n       = 1'b0;
        amp_data    = '0;
        amp_valid   = 1'b0;
        amp_thr     = '0;
        phase_data  = '0;
        phase_valid = 1'b0;
        phase_limit = '0;

        // Directed rows with expected values worked out by hand
        add_row(32'd1000, 32'd2000, 32'd10, 32'd100, 1'b0, 1'b1,
                pllg_state_pkg::REASON_AMP_LOW);
        add_row(32'd3000, 32'd2000, 32'd500, 32'd100, 1'b0, 1'b1,
                pllg_state_pkg::REASON_PHASE_UNLOCK);
        add_row(32'd3000, 32'd2000, pllg_types_pkg::phase_t'(-500), 32'd100, 1'b1, 1'b1,
                pllg_state_pkg::REASON_PHASE_UNLOCK);
        add_row(32'd3000, 32'd2000, pllg_types_pkg::phase_t'(-20), 32'd100, 1'b0, 1'b0,
                pllg_state_pkg::REASON_NONE);
        add_row(32'd5, 32'd10, pllg_types_pkg::phase_t'(-1000), 32'd10, 1'b0, 1'b1,
                pllg_state_pkg::REASON_BOTH);
        add_row(32'd3000, 32'd2000, 32'd40, 32'd100, 1'b1, 1'b0,
                pllg_state_pkg::REASON_NONE);
        // Boundaries
        add_row(32'd2000, 32'd2000, 32'd40, 32'd100, 1'b0, 1'b1,
                pllg_state_pkg::REASON_AMP_LOW);
        add_row(32'd2001, 32'd2000, 32'd100, 32'd100, 1'b0, 1'b0,
                pllg_state_pkg::REASON_NONE);
        add_row(32'd2001, 32'd2000, pllg_types_pkg::phase_t'(-100), 32'd100, 1'b1, 1'b0,
                pllg_state_pkg::REASON_NONE);
        add_row(32'd2001, 32'd2000, pllg_types_pkg::phase_t'(-101), 32'd100, 1'b0, 1'b1,
                pllg_state_pkg::REASON_PHASE_UNLOCK);
        for (int i = 0; i < NUM_RANDOM; i++)
            add_random_row();

        repeat (RST_CYCLES) @(posedge aclk);
        rst_n <= 1'b1;
        amp_valid <= 1'b1;

        // Safe state straight out of reset
        cur_row = -1;
        cur_cyc = 0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        check_hold(1'b1);
        check_reason(pllg_state_pkg::REASON_BOTH);

        for (int row = 0; row < NUM_ROWS; row++)
        begin
            cur_row  = row;
            prev_bad = (row == 0) ? 1'b1 : row_hold[row - 1];
            for (int cyc = 0; cyc < ROW_CYCLES; cyc++)
            begin
                @(posedge aclk);
                cur_cyc = cyc;
                if (cyc == 0)
                begin
                    amp_data    <= row_amp[row];
                    amp_thr     <= row_thr[row];
                    phase_data  <= row_phase[row];
                    phase_limit <= row_limit[row];
                end
                // Alternate pattern paces the phase stream only
                phase_valid <= !row_alt[row] || ((cyc % 2) == 0);
                @(negedge aclk);
                if ((cyc == EARLY_CYCLE - 1) && prev_bad && !row_hold[row])
                    check_hold(1'b1);
                if (cyc == ROW_CYCLES - 1)
                begin
                    check_hold(row_hold[row]);
                    check_reason(row_reason[row]);
                end
            end
        end

        $display("Error counts: hold %0d, hold_reason %0d, total %0d",
                 hold_errs, reason_errs, hold_errs + reason_errs);
        if ((hold_errs + reason_errs) == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/pllg_top.sv
`timescale 1ns/100ps
`default_nettype none

module pllg_top
(
    input  logic                        aclk,
    input  logic                        rst_n,
    input  pllg_types_pkg::amp_t         amp_data,
    input  logic                        amp_valid,
    input  pllg_types_pkg::amp_t         amp_thr,
    input  pllg_types_pkg::phase_t       phase_data,
    input  logic                        phase_valid,
    input  pllg_types_pkg::phase_lim_t   phase_limit,
    output logic                        hold,
    output pllg_state_pkg::hold_reason_t hold_reason
);

    // Amplitude at or below threshold
    logic amp_low;

    // Phase error settled inside its window
    logic phase_locked;

    //////////////////////////////////////////////////
    // Lock checks
    //////////////////////////////////////////////////

    amplitude_good i_amplitude_good
    (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .amp_data  (amp_data),
        .amp_valid (amp_valid),
        .amp_thr   (amp_thr),
        .amp_low   (amp_low)
    );

    phase_window_lock i_phase_window_lock
    (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .phase_data   (phase_data),
        .phase_valid  (phase_valid),
        .phase_limit  (phase_limit),
        .phase_locked (phase_locked)
    );

    // Freezes the loop controllers on either failure
    hold_controller i_hold_controller
    (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .amp_low      (amp_low),
        .phase_locked (phase_locked),
        .hold         (hold),
        .hold_reason  (hold_reason)
    );

endmodule

`default_nettype wire

// File: hdl/hold_controller.sv
`timescale 1ns/100ps
`default_nettype none

`include "pllg_params.svh"

module hold_controller
(
    input  logic                        aclk,
    input  logic                        rst_n,
    input  logic                        amp_low,
    input  logic                        phase_locked,
    output logic                        hold,
    output pllg_state_pkg::hold_reason_t hold_reason
);

    // Settle count on which TRACK is entered
    localparam pllg_types_pkg::run_cnt_t REL_LAST =
        pllg_types_pkg::run_cnt_t'(`PLLG_RELEASE_CYCLES - 1);

    pllg_state_pkg::guard_state_t state;
    pllg_state_pkg::guard_state_t state_nxt;

    // Good cycles spent in SETTLE
    pllg_types_pkg::run_cnt_t rel_cnt;

    // Both checks happy this cycle
    logic both_good;

    // Failure bits straight from the checks
    pllg_state_pkg::hold_reason_t reason_nxt;

    assign both_good = !amp_low && phase_locked;

    // Bit 1 phase, bit 0 amplitude
    assign reason_nxt = pllg_state_pkg::hold_reason_t'({!phase_locked, amp_low});

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        unique case (state)
            pllg_state_pkg::GUARD_HOLD:
                if (both_good)
                    state_nxt = pllg_state_pkg::GUARD_SETTLE;
            pllg_state_pkg::GUARD_SETTLE:
                // Any failure drops straight back
                if (!both_good)
                    state_nxt = pllg_state_pkg::GUARD_HOLD;
                else if (rel_cnt == REL_LAST)
                    state_nxt = pllg_state_pkg::GUARD_TRACK;
            pllg_state_pkg::GUARD_TRACK:
                if (!both_good)
                    state_nxt = pllg_state_pkg::GUARD_HOLD;
            default:
                state_nxt = pllg_state_pkg::GUARD_HOLD;
        endcase
    end

    //////////////////////////////////////////////////
    // Registers and outputs
    //////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            state       <= pllg_state_pkg::GUARD_HOLD;
            rel_cnt     <= '0;
            hold        <= 1'b1;
            hold_reason <= pllg_state_pkg::REASON_BOTH;
        end
        else
        begin
            state <= state_nxt;
            // Settle count restarts outside a good SETTLE
            if ((state == pllg_state_pkg::GUARD_SETTLE) && both_good)
                rel_cnt <= rel_cnt + 1'b1;
            else
                rel_cnt <= '0;
            // Loop runs free only in TRACK
            hold        <= (state_nxt != pllg_state_pkg::GUARD_TRACK);
            hold_reason <= reason_nxt;
        end
    end

    a_hold_low_only_in_track: assert property (
        @(posedge aclk) disable iff (!rst_n)
        !hold |-> (state == pllg_state_pkg::GUARD_TRACK)
    ) else $error("hold released outside GUARD_TRACK");

    // Tracking with a pending failure would be a missed hold
    a_track_has_no_reason: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (state == pllg_state_pkg::GUARD_TRACK) |-> (hold_reason == pllg_state_pkg::REASON_NONE)
    ) else $error("hold_reason set while in GUARD_TRACK");

endmodule

`default_nettype wire

// File: hdl/phase_window_lock.sv
`timescale 1ns/100ps
`default_nettype none

`include "pllg_params.svh"

module phase_window_lock
(
    input  logic                      aclk,
    input  logic                      rst_n,
    input  pllg_types_pkg::phase_t     phase_data,
    input  logic                      phase_valid,
    input  pllg_types_pkg::phase_lim_t phase_limit,
    output logic                      phase_locked
);

    // Run length that counts as locked
    localparam pllg_types_pkg::run_cnt_t LOCK_RUN =
        pllg_types_pkg::run_cnt_t'(`PLLG_LOCK_COUNT);

    // Last count before lock is reached
    localparam pllg_types_pkg::run_cnt_t LOCK_LAST =
        pllg_types_pkg::run_cnt_t'(`PLLG_LOCK_COUNT - 1);

    // Sign of the error
    logic phase_neg;

    // Unsigned magnitude of the error
    // Full scale negative maps onto the top bit
    pllg_types_pkg::phase_lim_t phase_mag;

    // Sample lies inside the symmetric window
    logic in_window;

    // Consecutive in-window valid samples
    pllg_types_pkg::run_cnt_t run_cnt;

    //////////////////////////////////////////////////
    // Window compare
    //////////////////////////////////////////////////

    assign phase_neg = ($signed(phase_data) < 0);

    // Two's complement negate on negative error
    assign phase_mag = phase_neg ? (~phase_data + 1'b1) : phase_data;

    // Edge of the window still counts as inside
    assign in_window = (phase_mag <= phase_limit);

    //////////////////////////////////////////////////
    // Lock qualifier
    //////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            run_cnt      <= '0;
            phase_locked <= 1'b0;
        end
        else if (phase_valid)
        begin
            if (in_window)
            begin
                // Count saturates at the lock run
                if (run_cnt != LOCK_RUN)
                    run_cnt <= run_cnt + 1'b1;
                // Lock together with the last counted sample
                if (run_cnt >= LOCK_LAST)
                    phase_locked <= 1'b1;
            end
            else
            begin
                // Any miss restarts the run
                run_cnt      <= '0;
                phase_locked <= 1'b0;
            end
        end
    end

    // Lock is never shown without a full run behind it
    a_lock_needs_full_run: assert property (
        @(posedge aclk) disable iff (!rst_n)
        phase_locked |-> (run_cnt == LOCK_RUN)
    ) else $error("phase_locked high with run counter short of lock count");

endmodule

`default_nettype wire

// File: hdl/amplitude_good.sv
`timescale 1ns/100ps
`default_nettype none

`include "pllg_params.svh"

module amplitude_good
(
    input  logic                aclk,
    input  logic                rst_n,
    input  pllg_types_pkg::amp_t amp_data,
    input  logic                amp_valid,
    input  pllg_types_pkg::amp_t amp_thr,
    output logic                amp_low
);

    localparam int DECIM_W = `PLLG_DECIM_LOG2;

    // Counter value on which the inputs are taken
    localparam logic [DECIM_W-1:0] CAPT_PHASE = 1;

    // Free-running decimation counter
    logic [DECIM_W-1:0] decim_cnt;

    // Captured amplitude and threshold pair
    pllg_types_pkg::amp_t amp_r;
    pllg_types_pkg::amp_t thr_r;

    // Set for one cycle after a capture
    logic capt_q;

    //////////////////////////////////////////////////
    // Decimated capture
    //////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            decim_cnt <= '0;
            capt_q    <= 1'b0;
        end
        else
        begin
            // Advances every cycle and wraps
            decim_cnt <= decim_cnt + 1'b1;
            capt_q    <= (decim_cnt == CAPT_PHASE) && amp_valid;
        end
    end

    // Amplitude and threshold sampled together
    always_ff @(posedge aclk)
    begin
        if ((decim_cnt == CAPT_PHASE) && amp_valid)
        begin
            amp_r <= amp_data;
            thr_r <= amp_thr;
        end
    end

    //////////////////////////////////////////////////
    // Threshold compare
    //////////////////////////////////////////////////

    // Good only when strictly above threshold
    // Low is the safe value out of reset
    always_ff @(posedge aclk)
    begin
        if (!rst_n)
            amp_low <= 1'b1;
        else if (capt_q)
            amp_low <= !(amp_r > thr_r);
    end

    // Output may only move on the cycle after a capture
    a_amp_low_after_capture: assert property (
        @(posedge aclk) disable iff (!rst_n)
        $changed(amp_low) |-> $past(capt_q)
    ) else $error("amp_low changed without a preceding capture");

endmodule

`default_nettype wire

// File: hdl/pllg_state_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// Control encodings of the PLL guard
//////////////////////////////////////////////////

package pllg_state_pkg;

    // Hold controller states
    typedef enum logic [1:0] {
        GUARD_HOLD   = 2'd0,
        GUARD_SETTLE = 2'd1,
        GUARD_TRACK  = 2'd2
    } guard_state_t;

    // Bit 0 amplitude low, bit 1 phase unlocked
    typedef enum logic [1:0] {
        REASON_NONE         = 2'd0,
        REASON_AMP_LOW      = 2'd1,
        REASON_PHASE_UNLOCK = 2'd2,
        REASON_BOTH         = 2'd3
    } hold_reason_t;

endpackage

`default_nettype wire

// File: hdl/pllg_types_pkg.sv
`default_nettype none

`include "pllg_params.svh"

//////////////////////////////////////////////////
// Data types of the PLL guard
//////////////////////////////////////////////////

package pllg_types_pkg;

    // Unsigned resonator amplitude or its threshold
    typedef logic [`PLLG_DATA_W-1:0] amp_t;

    // Phase error in two's complement
    // Interpreted as signed inside the RTL
    typedef logic [`PLLG_DATA_W-1:0] phase_t;

    // Non-negative half width of the phase window
    typedef logic [`PLLG_DATA_W-1:0] phase_lim_t;

    // Lock-run and release counters
    typedef logic [`PLLG_CNT_W-1:0] run_cnt_t;

endpackage

`default_nettype wire

// File: include/pllg_params.svh
`ifndef PLLG_PARAMS_SVH
`define PLLG_PARAMS_SVH

//////////////////////////////////////////////////
// PLL guard sizing
//////////////////////////////////////////////////

// Amplitude and phase sample width
`define PLLG_DATA_W 32

// Log2 of amplitude decimation
// 2 gives one capture every 4 cycles
`define PLLG_DECIM_LOG2 2

// Consecutive in-window phase samples for lock
`define PLLG_LOCK_COUNT 8

// Good cycles before hold is released
`define PLLG_RELEASE_CYCLES 16

// Lock-run and release counter width
// Must hold both counts above
`define PLLG_CNT_W 5

`endif
